// ==== Bender.yml ====
package:
  name: slurm_backend

sources:
  - hw/slurm_isa_pkg.sv
  - hw/slurm_pipe_pkg.sv
  - hw/pipe_stage_reg.sv
  - hw/mem_access.sv
  - hw/cpu_writeback.sv
  - hw/register_file.sv
  - hw/cpu_backend.sv
  - target: test
    files:
      - verif/cpu_backend_chk.sv
      - verif/cpu_backend_tb.sv

// ==== hw/cpu_backend.sv ====
// Top of the CPU back end; connect the execute stage issue bus, the I/O port and read ports.
`default_nettype none

module cpu_backend #(
	parameter int MEM_WORDS = 256
) (
	input  logic                    clk,
	input  logic                    rst,
	input  slurm_pipe_pkg::issue_t  issue,
	input  logic                    issue_valid,
	input  logic                    io_ack,
	input  logic [15:0]             io_rdata,
	input  slurm_isa_pkg::reg_idx_t rd_a_sel,
	input  slurm_isa_pkg::reg_idx_t rd_b_sel,
	output logic                    stall,
	output slurm_pipe_pkg::io_req_t io,
	output logic                    io_req,
	output logic [15:0]             rd_a_data,
	output logic [15:0]             rd_b_data
);
	import slurm_pipe_pkg::*;

	st3_t   st3;
	logic   st3_valid;
	st4_t   st4_next;
	logic   st4_next_valid;
	st4_t   st4;
	logic   st4_valid;
	rf_wr_t rf_wr;

	// ##################################################################
	// Stage registers
	// ##################################################################
	pipe_stage_reg #(.payload_t(st3_t)) u_st3_reg (
		.clk       (clk),
		.rst       (rst),
		.hold      (stall),      // Held during I/O.
		.in_valid  (issue_valid),
		.in_data   (issue),
		.out_valid (st3_valid),
		.out_data  (st3)
	);

	mem_access #(.MEM_WORDS(MEM_WORDS)) u_mem_access (
		.clk            (clk),
		.rst            (rst),
		.st3_valid      (st3_valid),
		.st3            (st3),
		.io_ack         (io_ack),
		.io_rdata       (io_rdata),
		.stall          (stall),
		.io             (io),
		.io_req         (io_req),
		.st4_next       (st4_next),
		.st4_next_valid (st4_next_valid)
	);

	pipe_stage_reg #(.payload_t(st4_t)) u_st4_reg (
		.clk       (clk),
		.rst       (rst),
		.hold      (1'b0),       // Stage 4 always drains.
		.in_valid  (st4_next_valid),
		.in_data   (st4_next),
		.out_valid (st4_valid),
		.out_data  (st4)
	);

	// ##################################################################
	// Writeback and registers
	// ##################################################################
	cpu_writeback u_writeback (
		.st4_valid (st4_valid),
		.st4       (st4),
		.rf_wr     (rf_wr)
	);

	register_file u_register_file (
		.clk       (clk),
		.rst       (rst),
		.rf_wr     (rf_wr),
		.rd_a_sel  (rd_a_sel),
		.rd_b_sel  (rd_b_sel),
		.rd_a_data (rd_a_data),
		.rd_b_data (rd_b_data)
	);

endmodule

`default_nettype wire

// ==== hw/cpu_writeback.sv ====
// Stage 4 of the back end: picks the destination register and the value written to it.
`default_nettype none

module cpu_writeback (
	input  logic                   st4_valid,
	input  slurm_pipe_pkg::st4_t   st4,
	output slurm_pipe_pkg::rf_wr_t rf_wr
);
	import slurm_isa_pkg::*;

	instr_t      ins;
	logic [7:0]  lane;
	logic [15:0] byte_zx;
	logic [15:0] byte_sx;

	assign ins = st4.instruction;

	// ##################################################################
	// Byte load data
	// ##################################################################
	assign lane    = (st4.byte_mask == 2'b10) ? st4.mem_rdata[15:8] : st4.mem_rdata[7:0];
	assign byte_zx = {8'h00, lane};
	assign byte_sx = {{8{lane[7]}}, lane}; // Copy bit 7 upward.

	// ##################################################################
	// Destination and value select
	// ##################################################################
	always_comb begin
		rf_wr.en   = 1'b0;
		rf_wr.sel  = '0;
		rf_wr.data = '0;

		if (!st4_valid) begin
			rf_wr.en = 1'b0; // Bubble.
		end else if (st4.irq_return) begin
			// Return address of the interrupted flow.
			rf_wr.en   = 1'b1;
			rf_wr.sel  = INTERRUPT_LINK_REGISTER;
			rf_wr.data = st4.pc;
		end else begin
			case (op_class(ins))
				alu_single: begin
					rf_wr.en   = 1'b1;
					rf_wr.sel  = reg_src(ins); // Operand is also the target.
					rf_wr.data = st4.alu_out;
				end
				alu_reg_reg, alu_reg_imm: begin
					rf_wr.en   = 1'b1;
					rf_wr.sel  = reg_dest(ins);
					rf_wr.data = st4.alu_out;
				end
				branch: begin
					if (is_link(ins)) begin
						rf_wr.en   = 1'b1;
						rf_wr.sel  = LINK_REGISTER;
						rf_wr.data = st4.pc + 16'd2;
					end
				end
				load_store: begin
					if (!is_store(ins)) begin
						rf_wr.en   = 1'b1;
						rf_wr.sel  = reg_dest(ins);
						rf_wr.data = st4.mem_rdata;
					end
				end
				byte_load_store: begin
					if (!is_store(ins)) begin
						rf_wr.en   = 1'b1;
						rf_wr.sel  = reg_dest(ins);
						rf_wr.data = byte_zx;
					end
				end
				byte_load_sx: begin
					rf_wr.en   = 1'b1; // Load only class.
					rf_wr.sel  = reg_dest(ins);
					rf_wr.data = byte_sx;
				end
				peek_poke: begin
					if (!is_poke(ins)) begin
						rf_wr.en   = 1'b1;
						rf_wr.sel  = reg_dest(ins);
						rf_wr.data = st4.port_rdata;
					end
				end
				cond_mov: begin
					// Flags are the ones carried with this item.
					if (cond_passes(ins, st4.flags)) begin
						rf_wr.en   = 1'b1;
						rf_wr.sel  = reg_dest(ins);
						rf_wr.data = st4.alu_out;
					end
				end
				three_reg_cond_alu: begin
					if (st4.cond_pass) begin
						rf_wr.en   = 1'b1;
						rf_wr.sel  = reg_dest3(ins);
						rf_wr.data = st4.alu_out;
					end
				end
				default: rf_wr.en = 1'b0; // Stores, pokes and unknown classes.
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/mem_access.sv ====
// Stage 3 of the back end: data memory, byte lanes and the I/O port handshake.
`default_nettype none

module mem_access #(
	parameter int MEM_WORDS = 256
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   st3_valid,
	input  slurm_pipe_pkg::st3_t   st3,
	input  logic                   io_ack,
	input  logic [15:0]            io_rdata,
	output logic                   stall,
	output slurm_pipe_pkg::io_req_t io,
	output logic                   io_req,
	output slurm_pipe_pkg::st4_t   st4_next,
	output logic                   st4_next_valid
);
	import slurm_isa_pkg::*;

	localparam int ADDR_BITS = $clog2(MEM_WORDS);

	typedef enum logic [1:0] {idle, wait_ack, wait_release} io_state_t;

	logic [1:0][7:0]      mem [MEM_WORDS]; // Two byte lanes per word.
	logic [ADDR_BITS-1:0] word_addr;
	logic [1:0]           byte_mask;
	logic [15:0]          mem_wdata;
	logic                 is_byte;
	logic                 mem_we;
	logic                 is_io;
	logic                 io_done;
	io_state_t            state_q;
	io_state_t            state_d;
	logic [15:0]          port_rdata_q;

	// ##################################################################
	// Data memory
	// ##################################################################
	assign word_addr = st3.alu_out[ADDR_BITS:1]; // Bit 0 selects the byte.
	assign is_byte   = (op_class(st3.instruction) == byte_load_store) ||
	                   (op_class(st3.instruction) == byte_load_sx);

	// Even address is the high byte.
	assign byte_mask = !is_byte ? 2'b11 : (st3.alu_out[0] ? 2'b01 : 2'b10);
	assign mem_wdata = is_byte ? {2{st3.store_data[7:0]}} : st3.store_data;

	assign mem_we = st3_valid && is_store(st3.instruction) &&
	                ((op_class(st3.instruction) == load_store) ||
	                 (op_class(st3.instruction) == byte_load_store));

	always_ff @(posedge clk) begin
		if (mem_we && byte_mask[1]) begin
			mem[word_addr][1] <= mem_wdata[15:8];
		end
		if (mem_we && byte_mask[0]) begin
			mem[word_addr][0] <= mem_wdata[7:0];
		end
	end

	// ##################################################################
	// I/O handshake
	// ##################################################################
	assign is_io   = st3_valid && (op_class(st3.instruction) == peek_poke);
	assign io_done = (state_q == wait_release) && !io_ack; // Release seen.

	always_comb begin
		state_d = state_q;
		case (state_q)
			idle:         if (is_io && !io_ack) state_d = wait_ack;
			wait_ack:     if (io_ack) state_d = wait_release;
			wait_release: if (!io_ack) state_d = idle;
			default:      state_d = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= idle;
		end else begin
			state_q <= state_d;
		end
	end

	// Peek data sampled with the acknowledge.
	always_ff @(posedge clk) begin
		if (state_q == wait_ack && io_ack) begin
			port_rdata_q <= io_rdata;
		end
	end

	assign io_req   = (state_q == wait_ack);
	assign io.addr  = st3.alu_out;
	assign io.wdata = st3.store_data;
	assign io.write = is_poke(st3.instruction);

	assign stall = is_io && !io_done;

	// Next stage gets a bubble while held.
	assign st4_next_valid = st3_valid && !stall;

	always_comb begin
		st4_next.instruction = st3.instruction;
		st4_next.alu_out     = st3.alu_out;
		st4_next.pc          = st3.pc;
		st4_next.flags       = st3.flags;
		st4_next.cond_pass   = st3.cond_pass;
		st4_next.irq_return  = st3.irq_return;
		st4_next.mem_rdata   = mem[word_addr];
		st4_next.port_rdata  = port_rdata_q;
		st4_next.byte_mask   = byte_mask;
	end

endmodule

`default_nettype wire

// ==== hw/pipe_stage_reg.sv ====
// Pipeline register with a valid bit; set payload_t to the stage payload struct.
`default_nettype none

module pipe_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     hold,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	// Valid bit.
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (!hold) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			out_data <= in_data; // Payload follows valid.
		end
	end

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
// General register file of the back end; one write port from writeback, two read ports out.
`default_nettype none

module register_file (
	input  logic                                 clk,
	input  logic                                 rst,
	input  slurm_pipe_pkg::rf_wr_t               rf_wr,
	input  slurm_isa_pkg::reg_idx_t              rd_a_sel,
	input  slurm_isa_pkg::reg_idx_t              rd_b_sel,
	output logic [slurm_isa_pkg::DATA_BITS-1:0]  rd_a_data,
	output logic [slurm_isa_pkg::DATA_BITS-1:0]  rd_b_data
);
	import slurm_isa_pkg::*;

	logic [DATA_BITS-1:0] regs [16];

	// ##################################################################
	// Write port
	// ##################################################################
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (rf_wr.en) begin
			regs[rf_wr.sel] <= rf_wr.data;
		end
	end

	// ##################################################################
	// Read ports
	// ##################################################################

	// A write shows only after the edge.
	assign rd_a_data = (rd_a_sel == '0) ? '0 : regs[rd_a_sel]; // r0 is hardwired.
	assign rd_b_data = (rd_b_sel == '0) ? '0 : regs[rd_b_sel];

endmodule

`default_nettype wire

// ==== hw/slurm_isa_pkg.sv ====
// Instruction set definitions for the back end; import into stages that decode instructions.
`default_nettype none

package slurm_isa_pkg;

	localparam int DATA_BITS = 16; // Fixed by the instruction format.

	typedef logic [DATA_BITS-1:0] instr_t;
	typedef logic [3:0]           reg_idx_t;

	// ##################################################################
	// Field positions
	// ##################################################################
	localparam int OPC_MSB    = 15;
	localparam int OPC_LSB    = 12;
	localparam int DEST3_MSB  = 11; // Three-register destination.
	localparam int DEST3_LSB  = 8;
	localparam int DEST_MSB   = 7;
	localparam int DEST_LSB   = 4;
	localparam int SRC_MSB    = 3;  // Also the condition code.
	localparam int SRC_LSB    = 0;
	localparam int LS_DIR_BIT = 8;  // Zero means load.
	localparam int LINK_BIT   = 8;
	localparam int POKE_BIT   = 8;

	// Other opcode classes do nothing in the back end.
	typedef enum logic [3:0] {
		alu_single         = 4'h1,
		alu_reg_reg        = 4'h2,
		alu_reg_imm        = 4'h3,
		branch             = 4'h4,
		load_store         = 4'h5,
		byte_load_store    = 4'h6,
		byte_load_sx       = 4'h7,
		peek_poke          = 4'h8,
		cond_mov           = 4'h9,
		three_reg_cond_alu = 4'ha
	} op_class_t;

	localparam reg_idx_t LINK_REGISTER           = 4'd15;
	localparam reg_idx_t INTERRUPT_LINK_REGISTER = 4'd14;

	// Codes 9 to 15 never pass.
	typedef enum logic [3:0] {
		eq = 4'd0, ne = 4'd1, cs = 4'd2, cc = 4'd3,
		mi = 4'd4, pl = 4'd5, vs = 4'd6, vc = 4'd7,
		al = 4'd8
	} cond_t;

	typedef struct packed {
		logic z;
		logic c;
		logic s;
		logic v;
	} flags_t;

	// ##################################################################
	// Field decode helpers
	// ##################################################################
	function automatic op_class_t op_class(instr_t ins);
		return op_class_t'(ins[OPC_MSB:OPC_LSB]);
	endfunction

	function automatic reg_idx_t reg_dest(instr_t ins);
		return ins[DEST_MSB:DEST_LSB];
	endfunction

	function automatic reg_idx_t reg_dest3(instr_t ins);
		return ins[DEST3_MSB:DEST3_LSB];
	endfunction

	function automatic reg_idx_t reg_src(instr_t ins);
		return ins[SRC_MSB:SRC_LSB];
	endfunction

	function automatic logic is_store(instr_t ins);
		return ins[LS_DIR_BIT];
	endfunction

	function automatic logic is_link(instr_t ins);
		return ins[LINK_BIT];
	endfunction

	function automatic logic is_poke(instr_t ins);
		return ins[POKE_BIT];
	endfunction

	function automatic logic cond_passes(instr_t ins, flags_t f);
		case (cond_t'(ins[SRC_MSB:SRC_LSB]))
			eq:      return f.z;
			ne:      return !f.z;
			cs:      return f.c;
			cc:      return !f.c;
			mi:      return f.s;
			pl:      return !f.s;
			vs:      return f.v;
			vc:      return !f.v;
			al:      return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== hw/slurm_pipe_pkg.sv ====
// Payload and bus structs passed between back-end stages; import where the structs are built.
`default_nettype none

package slurm_pipe_pkg;

	// ##################################################################
	// Pipeline payloads
	// ##################################################################

	// Item handed over by the execute stage.
	typedef struct packed {
		slurm_isa_pkg::instr_t instruction;
		logic [15:0]           alu_out;
		logic [15:0]           store_data;
		logic [15:0]           pc;
		slurm_isa_pkg::flags_t flags;
		logic                  cond_pass;  // Condition resolved upstream.
		logic                  irq_return;
	} issue_t;

	typedef issue_t st3_t; // Stage 3 carries the issue item unchanged.

	typedef struct packed {
		slurm_isa_pkg::instr_t instruction;
		logic [15:0]           alu_out;
		logic [15:0]           pc;
		slurm_isa_pkg::flags_t flags;
		logic                  cond_pass;
		logic                  irq_return;
		logic [15:0]           mem_rdata;  // Writeback picks the byte lane.
		logic [15:0]           port_rdata;
		logic [1:0]            byte_mask;  // 10 high, 01 low, 11 word.
	} st4_t;

	// ##################################################################
	// Buses
	// ##################################################################
	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] wdata;
		logic        write; // Set for a poke.
	} io_req_t;

	typedef struct packed {
		logic                    en;
		slurm_isa_pkg::reg_idx_t sel;
		logic [15:0]             data;
	} rf_wr_t;

endpackage

`default_nettype wire

// ==== slurm_backend.f ====
hw/slurm_isa_pkg.sv
hw/slurm_pipe_pkg.sv
hw/pipe_stage_reg.sv
hw/mem_access.sv
hw/cpu_writeback.sv
hw/register_file.sv
hw/cpu_backend.sv
verif/cpu_backend_chk.sv
verif/cpu_backend_tb.sv

// ==== verif/cpu_backend_chk.sv ====
// Assertions on the I/O handshake and stall of the back end; bound into cpu_backend.
`default_nettype none

module cpu_backend_chk (
	input wire logic                    clk,
	input wire logic                    rst,
	input wire logic                    stall,
	input wire logic                    io_req,
	input wire logic                    io_ack,
	input wire slurm_pipe_pkg::io_req_t io
);

	int req_fail = 0;    // Failure counts.
	int stable_fail = 0;
	int reset_fail = 0;

	// A new request only starts once the device has released.
	req_after_release: assert property (@(posedge clk) disable iff (rst)
		$rose(io_req) |-> !$past(io_ack))
		else begin
			req_fail++;
			$error("io_req rose while io_ack was high");
		end

	io_stable: assert property (@(posedge clk) disable iff (rst)
		io_req && $past(io_req) |-> io == $past(io))
		else begin
			stable_fail++;
			$error("io changed while io_req was high");
		end

	stall_after_reset: assert property (@(posedge clk)
		$fell(rst) |-> !stall)
		else begin
			reset_fail++;
			$error("stall was high right after reset");
		end

endmodule

bind cpu_backend cpu_backend_chk u_chk (
	.clk    (clk),
	.rst    (rst),
	.stall  (stall),
	.io_req (io_req),
	.io_ack (io_ack),
	.io     (io)
);

`default_nettype wire

// ==== verif/cpu_backend_tb.sv ====
// Directed testbench for the back end; compile with the file list and run cpu_backend_tb.
`default_nettype none

module cpu_backend_tb;
	import slurm_isa_pkg::*;
	import slurm_pipe_pkg::*;

	localparam int CLK_PERIOD     = 20;
	localparam int SAMPLE_DELAY   = 5;  // After the falling edge.
	localparam int TIMEOUT_CYCLES = 200;
	localparam int STREAM_ITEMS   = 48;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic        clk = 1'b0;
	logic        rst = 1'b1;
	issue_t      issue;
	logic        issue_valid;
	logic        io_ack = 1'b0;
	logic [15:0] io_rdata = '0;
	reg_idx_t    rd_a_sel;
	reg_idx_t    rd_b_sel;
	logic        stall;
	io_req_t     io;
	logic        io_req;
	logic [15:0] rd_a_data;
	logic [15:0] rd_b_data;

	logic [31:0] lfsr_state = 32'd85909;
	logic [15:0] model [16];   // Expected register file.
	logic [15:0] io_table [16];
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          test_err_start = 0;

	// Responder state and log of the last request.
	typedef enum logic [1:0] {r_idle, r_delay_ack, r_hold, r_delay_rel} resp_state_t;
	resp_state_t resp_state = r_idle;
	logic [15:0] resp_count = '0;
	logic [15:0] seen_addr = '0;
	logic [15:0] seen_wdata = '0;
	logic        seen_write = 1'b0;
	int          handshakes = 0;

	cpu_backend #(.MEM_WORDS(256)) dut (
		.clk         (clk),
		.rst         (rst),
		.issue       (issue),
		.issue_valid (issue_valid),
		.io_ack      (io_ack),
		.io_rdata    (io_rdata),
		.rd_a_sel    (rd_a_sel),
		.rd_b_sel    (rd_b_sel),
		.stall       (stall),
		.io          (io),
		.io_req      (io_req),
		.rd_a_data   (rd_a_data),
		.rd_b_data   (rd_b_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ##################################################################
	// Random numbers and helpers
	// ##################################################################
	function automatic logic lfsr_step();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b) begin
			lfsr_state = lfsr_state ^ LFSR_TAPS;
		end
		return b;
	endfunction

	function automatic logic [15:0] rand_bits(int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr_step()}; // One step per bit.
		end
		return v;
	endfunction

	function automatic instr_t make_ins(logic [3:0] cls, logic [3:0] hi, logic [3:0] mid,
	                                    logic [3:0] lo);
		return {cls, hi, mid, lo};
	endfunction

	function automatic issue_t make_item(instr_t ins, logic [15:0] alu, logic [15:0] sd,
	                                     logic [15:0] pc, logic [3:0] f, logic cp, logic irq);
		issue_t it;
		it.instruction = ins;
		it.alu_out     = alu;
		it.store_data  = sd;
		it.pc          = pc;
		it.flags       = flags_t'(f);
		it.cond_pass   = cp;
		it.irq_return  = irq;
		return it;
	endfunction

	// Flags ordered z, c, s, v; odd codes test the cleared flag.
	function automatic logic expect_pass(logic [3:0] code, logic [3:0] f);
		if (code == 4'd8) begin
			return 1'b1;
		end
		if (code > 4'd8) begin
			return 1'b0;
		end
		return f[3 - code[2:1]] ^ code[0];
	endfunction

	function automatic void model_write(reg_idx_t r, logic [15:0] v);
		if (r != 4'd0) begin
			model[r] = v; // r0 stays zero.
		end
	endfunction

	// ##################################################################
	// I/O device model
	// ##################################################################
	always @(negedge clk) begin
		case (resp_state)
			r_idle: if (io_req) begin
				seen_addr  = io.addr;
				seen_wdata = io.wdata;
				seen_write = io.write;
				resp_count = rand_bits(2);
				resp_state = r_delay_ack;
			end
			r_delay_ack: if (resp_count == 0) begin
				io_ack     = 1'b1;
				io_rdata   = io.write ? 16'h0000 : io_table[io.addr[3:0]];
				resp_state = r_hold;
			end else begin
				resp_count = resp_count - 1;
			end
			r_hold: if (!io_req) begin
				resp_count = rand_bits(2);
				resp_state = r_delay_rel;
			end
			r_delay_rel: if (resp_count == 0) begin
				io_ack     = 1'b0; // Release ends the handshake.
				handshakes = handshakes + 1;
				resp_state = r_idle;
			end else begin
				resp_count = resp_count - 1;
			end
			default: resp_state = r_idle;
		endcase
	end

	// ##################################################################
	// Driving, reading and checking
	// ##################################################################
	task automatic abort_on_timeout(input string what);
		$display("timeout: %s", what);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
	                           input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// Holds the item until stall is low and returns after the accepting edge.
	task automatic issue_item(input issue_t item, output int waited);
		int n;
		@(negedge clk);
		issue       = item;
		issue_valid = 1'b1;
		n = 0;
		#SAMPLE_DELAY;
		while (stall) begin
			if (n == TIMEOUT_CYCLES) begin
				abort_on_timeout("stall stayed high while issuing");
			end
			@(negedge clk);
			#SAMPLE_DELAY;
			n++;
		end
		waited = n;
		@(posedge clk);
	endtask

	task automatic send(input issue_t item);
		int w;
		issue_item(item, w);
	endtask

	task automatic drain_pipeline();
		int n;
		@(negedge clk);
		issue_valid = 1'b0;
		n = 0;
		#SAMPLE_DELAY;
		while (stall) begin
			if (n == TIMEOUT_CYCLES) begin
				abort_on_timeout("stall stayed high while draining");
			end
			@(negedge clk);
			#SAMPLE_DELAY;
			n++;
		end
		repeat (2) @(posedge clk); // Memory stage and then the register write.
	endtask

	task automatic check_regs();
		for (int r = 0; r < 16; r++) begin
			@(negedge clk);
			rd_a_sel = reg_idx_t'(r);
			rd_b_sel = reg_idx_t'(15 - r);
			#SAMPLE_DELAY;
			check_value($sformatf("rd_a_data[r%0d]", r), rd_a_data, model[r]);
			check_value($sformatf("rd_b_data[r%0d]", 15 - r), rd_b_data, model[15 - r]);
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("%s: finished, %0d errors", name, errors - test_err_start);
		test_err_start = errors;
	endtask

	// ##################################################################
	// Tests
	// ##################################################################
	task automatic test_alu();
		send(make_item(make_ins(alu_reg_reg, 4'h0, 4'h3, 4'h9), 16'h1111, 0, 0, 0, 0, 0));
		send(make_item(make_ins(alu_reg_imm, 4'h0, 4'h4, 4'h1), 16'h2222, 0, 0, 0, 0, 0));
		send(make_item(make_ins(alu_single, 4'h0, 4'h6, 4'h5), 16'h3333, 0, 0, 0, 0, 0));
		send(make_item(make_ins(three_reg_cond_alu, 4'h6, 4'h2, 4'h1), 16'h4444, 0, 0, 0, 1, 0));
		send(make_item(make_ins(three_reg_cond_alu, 4'h7, 4'h2, 4'h1), 16'h5555, 0, 0, 0, 0, 0));
		send(make_item(make_ins(alu_reg_reg, 4'h0, 4'h0, 4'h2), 16'hffff, 0, 0, 0, 0, 0));
		send(make_item(make_ins(alu_single, 4'h0, 4'h8, 4'h0), 16'heeee, 0, 0, 0, 0, 0));
		drain_pipeline();
		model_write(3, 16'h1111);
		model_write(4, 16'h2222);
		model_write(5, 16'h3333);
		model_write(6, 16'h4444); // r7 keeps its value and r0 reads zero.
		check_regs();
		finish_test("alu");
	endtask

	task automatic test_link();
		send(make_item(make_ins(branch, 4'h1, 4'h0, 4'h0), 0, 0, 16'h0100, 0, 0, 0));
		send(make_item(make_ins(branch, 4'h0, 4'h0, 4'h0), 0, 0, 16'h0200, 0, 0, 0));
		send(make_item(make_ins(4'h0, 4'h0, 4'h0, 4'h0), 0, 0, 16'h0300, 0, 0, 1));
		drain_pipeline();
		model_write(LINK_REGISTER, 16'h0102);
		model_write(INTERRUPT_LINK_REGISTER, 16'h0300);
		check_regs();
		finish_test("link");
	endtask

	task automatic test_memory();
		send(make_item(make_ins(load_store, 4'h1, 4'h0, 4'h0), 16'h0010, 16'ha55a, 0, 0, 0, 0));
		send(make_item(make_ins(load_store, 4'h0, 4'h1, 4'h0), 16'h0010, 0, 0, 0, 0, 0));
		// Upper store byte must be ignored.
		send(make_item(make_ins(byte_load_store, 4'h1, 4'h0, 4'h0), 16'h0020, 16'h127f, 0, 0, 0, 0));
		send(make_item(make_ins(byte_load_store, 4'h1, 4'h0, 4'h0), 16'h0021, 16'h3480, 0, 0, 0, 0));
		send(make_item(make_ins(byte_load_store, 4'h1, 4'h0, 4'h0), 16'h0030, 16'h0080, 0, 0, 0, 0));
		send(make_item(make_ins(byte_load_store, 4'h1, 4'h0, 4'h0), 16'h0031, 16'h007f, 0, 0, 0, 0));
		send(make_item(make_ins(byte_load_store, 4'h0, 4'h2, 4'h0), 16'h0020, 0, 0, 0, 0, 0));
		send(make_item(make_ins(byte_load_store, 4'h0, 4'h3, 4'h0), 16'h0021, 0, 0, 0, 0, 0));
		send(make_item(make_ins(byte_load_sx, 4'h0, 4'h4, 4'h0), 16'h0020, 0, 0, 0, 0, 0));
		send(make_item(make_ins(byte_load_sx, 4'h0, 4'h5, 4'h0), 16'h0021, 0, 0, 0, 0, 0));
		send(make_item(make_ins(load_store, 4'h0, 4'h6, 4'h0), 16'h0020, 0, 0, 0, 0, 0));
		send(make_item(make_ins(byte_load_sx, 4'h0, 4'hb, 4'h0), 16'h0030, 0, 0, 0, 0, 0));
		send(make_item(make_ins(byte_load_store, 4'h0, 4'hc, 4'h0), 16'h0031, 0, 0, 0, 0, 0));
		send(make_item(make_ins(byte_load_sx, 4'h0, 4'hd, 4'h0), 16'h0031, 0, 0, 0, 0, 0));
		drain_pipeline();
		model_write(1, 16'ha55a);
		model_write(2, 16'h007f);  // Even address is the high lane.
		model_write(3, 16'h0080);
		model_write(4, 16'h007f);
		model_write(5, 16'hff80);
		model_write(6, 16'h7f80);
		model_write(11, 16'hff80);
		model_write(12, 16'h007f);
		model_write(13, 16'h007f);
		check_regs();
		finish_test("memory");
	endtask

	task automatic test_cond_mov();
		logic [3:0]  patterns [4];
		logic [15:0] v;
		patterns = '{4'b0000, 4'b1111, 4'b1010, 4'b0101};
		for (int code = 0; code < 16; code++) begin
			for (int p = 0; p < 4; p++) begin
				v = 16'h0d00 | 16'(code << 4) | 16'(p); // Marker before the move.
				send(make_item(make_ins(alu_reg_reg, 4'h0, 4'(10 + p), 4'h0), v, 0, 0, 0, 0, 0));
				model_write(reg_idx_t'(10 + p), v);
			end
			for (int p = 0; p < 4; p++) begin
				v = 16'hc000 | 16'(code << 4) | 16'(p);
				send(make_item(make_ins(cond_mov, 4'h0, 4'(10 + p), 4'(code)), v, 0, 0,
				               patterns[p], 0, 0));
				if (expect_pass(4'(code), patterns[p])) begin
					model_write(reg_idx_t'(10 + p), v);
				end
			end
			drain_pipeline();
			check_regs();
		end
		finish_test("cond_mov");
	endtask

	task automatic test_io();
		int hs_start;
		int w;
		hs_start = handshakes;
		send(make_item(make_ins(peek_poke, 4'h1, 4'h0, 4'h0), 16'h00c4, 16'hbeef, 0, 0, 0, 0));
		issue_item(make_item(make_ins(alu_reg_reg, 4'h0, 4'h9, 4'h0), 16'h0909, 0, 0, 0, 0, 0), w);
		checks++;
		if (w == 0) begin
			errors++;
			$display("item behind the poke was not held by stall");
		end
		check_value("io_ack", {15'h0, io_ack}, 16'h0000);
		drain_pipeline();
		check_value("io.addr", seen_addr, 16'h00c4);
		check_value("io.wdata", seen_wdata, 16'hbeef);
		check_value("io.write", {15'h0, seen_write}, 16'h0001);
		model_write(9, 16'h0909);

		// Second peek and the ALU item overwrite r8 in issue order.
		send(make_item(make_ins(peek_poke, 4'h0, 4'h7, 4'h0), 16'h000b, 0, 0, 0, 0, 0));
		issue_item(make_item(make_ins(peek_poke, 4'h0, 4'h8, 4'h0), 16'h0005, 0, 0, 0, 0, 0), w);
		issue_item(make_item(make_ins(alu_reg_reg, 4'h0, 4'h8, 4'h0), 16'h0808, 0, 0, 0, 0, 0), w);
		checks++;
		if (w == 0) begin
			errors++;
			$display("item behind the peek was not held by stall");
		end
		drain_pipeline();
		check_value("io.write", {15'h0, seen_write}, 16'h0000);
		check_value("handshakes", 16'(handshakes - hs_start), 16'd3);
		model_write(7, io_table[4'hb]);
		model_write(8, 16'h0808);
		check_regs();
		finish_test("io");
	endtask

	task automatic test_stream();
		logic [1:0]  kind;
		reg_idx_t    r;
		logic [3:0]  other;
		logic [15:0] v;
		logic        cp;
		for (int i = 0; i < STREAM_ITEMS; i++) begin
			kind  = 2'(rand_bits(2));
			r     = 4'(rand_bits(4));
			other = 4'(rand_bits(4));
			v     = rand_bits(16);
			cp    = 1'(rand_bits(1));
			case (kind)
				2'd0: send(make_item(make_ins(alu_reg_reg, 4'h0, r, other), v, 0, 0, 0, 0, 0));
				2'd1: send(make_item(make_ins(alu_single, 4'h0, other, r), v, 0, 0, 0, 0, 0));
				2'd2: send(make_item(make_ins(alu_reg_imm, 4'h0, r, other), v, 0, 0, 0, 0, 0));
				default: send(make_item(make_ins(three_reg_cond_alu, r, other, 4'h0), v, 0, 0,
				                        0, cp, 0));
			endcase
			if (kind != 2'd3 || cp) begin
				model_write(r, v);
			end
		end
		drain_pipeline();
		check_regs();
		finish_test("stream");
	endtask

	// ##################################################################
	// Main sequence
	// ##################################################################
	initial begin
		issue       = '0;
		issue_valid = 1'b0;
		rd_a_sel    = '0;
		rd_b_sel    = '0;
		for (int i = 0; i < 16; i++) begin
			model[i]    = '0;
			io_table[i] = 16'(i * 16'h1357) ^ 16'ha5c3;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_alu();
		test_link();
		test_memory();
		test_cond_mov();
		test_io();
		test_stream();

		errors = errors + dut.u_chk.req_fail + dut.u_chk.stable_fail + dut.u_chk.reset_fail;
		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
